// File: build.f
+incdir+rtl
rtl/core_bus_pkg.sv
rtl/core_av_pkg.sv
rtl/core_cfg_if.sv
rtl/core_regs.sv
rtl/video_timing.sv
rtl/i2s_tx.sv
rtl/core_top.sv
test/core_top_checker.sv
test/core_top_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := core_top_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/core_top_tb.sv
/*
  testbench for core_top, bridge table first, then one video frame and one stereo frame
  inputs change on the rising edge, outputs are sampled on the falling edge
  run time is bounded by a watchdog of three frames plus the table
*/
`default_nettype none
`include "core_macros.svh"

module core_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import core_bus_pkg::*;
    import core_av_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int TABLE_LEN    = 13;
    localparam int FRAME_CYCLES = `CORE_H_TOTAL * `CORE_V_TOTAL;
    localparam int WATCHDOG_CYCLES = 3 * FRAME_CYCLES + TABLE_LEN * 4;

    logic    audgen_mclk = 1'b0;
    logic    reset_n;
    word_t   bridge_addr;
    logic    bridge_rd;
    logic    bridge_wr;
    word_t   bridge_wr_data;
    word_t   bridge_rd_data;
    rgb_t    video_rgb;
    logic    video_de;
    logic    video_hs;
    logic    video_vs;
    logic    video_skip;
    logic    audio_mclk;
    logic    audio_sclk;
    logic    audio_lrck;
    logic    audio_dac;

    // bridge table: address, write flag, write data, expected read
    word_t   tbl_addr [TABLE_LEN];
    logic    tbl_wr   [TABLE_LEN];
    word_t   tbl_wdata[TABLE_LEN];
    word_t   tbl_exp  [TABLE_LEN];

    // register model
    rgb_t    exp_fill;
    sample_t exp_left;
    sample_t exp_right;

    word_t   rng = 32'd13;
    int      vs_count = 0;
    int      mclk_out_n = 0;
    int      word_errs = 0;
    int      rgb_errs = 0;
    int      sample_errs = 0;

    core_top dut_i (.*);

    always #(CLK_PERIOD / 2) audgen_mclk = ~audgen_mclk;

    // vs pulses since reset
    always @(negedge audgen_mclk) begin
        if (reset_n && video_vs) begin
            vs_count <= vs_count + 1;
        end
    end

    // codec clock edges, compared with audgen_mclk cycles in the audio check
    always @(posedge audio_mclk) begin
        mclk_out_n <= mclk_out_n + 1;
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            word_errs++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            rgb_errs++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            sample_errs++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic word_t xorshift32(input word_t s);
        word_t v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // register offset sits in bits 3:2
    function automatic word_t addr_of(input logic [7:0] region, input reg_sel_e sel);
        return {region, 20'd0, 2'(sel), 2'b00};
    endfunction

    task automatic set_row(input int i, input word_t addr, input logic wr, input word_t wdata,
                           input word_t exp);
        tbl_addr[i]  = addr;
        tbl_wr[i]    = wr;
        tbl_wdata[i] = wdata;
        tbl_exp[i]   = exp;
    endtask

    task automatic write_reg(input word_t addr, input word_t data);
        @(posedge audgen_mclk);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge audgen_mclk);
        bridge_wr      <= 1'b0;
    endtask

    // read data is combinational, sampled half a cycle after the address
    task automatic read_reg(input word_t addr, output word_t data);
        @(posedge audgen_mclk);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(negedge audgen_mclk);
        data = bridge_rd_data;
        @(posedge audgen_mclk);
        bridge_rd   <= 1'b0;
    endtask

    task automatic build_table;
        word_t r[7];
        logic [7:0] outside;
        outside = 8'h20;
        foreach (r[k]) begin
            rng  = xorshift32(rng);
            r[k] = rng;
        end
        exp_fill  = r[0][23:0];
        exp_left  = r[1][15:0];
        exp_right = r[2][15:0];
        // values after reset
        set_row(0, addr_of(`CORE_REG_REGION, REG_FILL_RGB), 1'b0, '0, '0);
        set_row(1, addr_of(`CORE_REG_REGION, REG_AUDIO_LEFT), 1'b0, '0, '0);
        set_row(2, addr_of(`CORE_REG_REGION, REG_AUDIO_RIGHT), 1'b0, '0, '0);
        // read back what was written, samples keep 16 bits
        set_row(3, addr_of(`CORE_REG_REGION, REG_FILL_RGB), 1'b1, r[0], {8'h00, exp_fill});
        set_row(4, addr_of(`CORE_REG_REGION, REG_AUDIO_LEFT), 1'b1, r[1], {16'h0000, exp_left});
        set_row(5, addr_of(`CORE_REG_REGION, REG_AUDIO_RIGHT), 1'b1, r[2], {16'h0000, exp_right});
        // write ignored, one vs right after reset
        set_row(6, addr_of(`CORE_REG_REGION, REG_FRAME_COUNT), 1'b1, r[3], 32'd1);
        // outside the region, reads zero
        set_row(7, addr_of(outside, REG_FILL_RGB), 1'b1, r[4], '0);
        set_row(8, addr_of(outside, REG_AUDIO_LEFT), 1'b1, r[5], '0);
        set_row(9, addr_of(outside, REG_AUDIO_RIGHT), 1'b1, r[6], '0);
        // registers untouched by those writes
        set_row(10, addr_of(`CORE_REG_REGION, REG_FILL_RGB), 1'b0, '0, {8'h00, exp_fill});
        set_row(11, addr_of(`CORE_REG_REGION, REG_AUDIO_LEFT), 1'b0, '0, {16'h0000, exp_left});
        set_row(12, addr_of(`CORE_REG_REGION, REG_AUDIO_RIGHT), 1'b0, '0, {16'h0000, exp_right});
    endtask

    //////////////////////////////
    // video and audio checks
    //////////////////////////////

    // one full frame from vs to the next vs
    task automatic check_frame;
        int cycles = 0;
        int de_total = 0;
        int de_runs = 0;
        int run_len = 0;
        int hs_gap = 0;
        int skip_n = 0;
        logic hs_seen = 1'b0;
        @(negedge audgen_mclk);
        while (!video_vs) @(negedge audgen_mclk);
        do begin
            @(negedge audgen_mclk);
            cycles++;
            hs_gap++;
            if (video_skip) skip_n++;
            if (video_de) begin
                de_total++;
                run_len++;
                check_rgb("video_rgb in active area", video_rgb, exp_fill);
            end else begin
                if (run_len != 0) begin
                    de_runs++;
                    check_word("video_de run length", run_len, `CORE_H_ACTIVE);
                    run_len = 0;
                end
                check_rgb("video_rgb in blanking", video_rgb, '0);
            end
            if (video_hs) begin
                if (hs_seen) check_word("video_hs period", hs_gap, `CORE_H_TOTAL);
                hs_seen = 1'b1;
                hs_gap  = 0;
            end
        end while (!video_vs);
        check_word("video_vs period", cycles, FRAME_CYCLES);
        check_word("video_de cycles per frame", de_total, `CORE_H_ACTIVE * `CORE_V_ACTIVE);
        check_word("video_de runs per frame", de_runs, `CORE_V_ACTIVE);
        check_word("video_skip cycles", skip_n, 0);
    endtask

    // one stereo frame, captured on rising sclk from the start of a left slot
    task automatic check_audio;
        logic [63:0] bits = '0;
        int rises = 0;
        int right_at = 0;
        int left_at = 0;
        int mclk_n = 0;
        int mclk_total = 0;
        int mclk_out_start;
        logic sclk_q;
        logic lrck_q;
        @(negedge audgen_mclk);
        do begin
            lrck_q = audio_lrck;
            @(negedge audgen_mclk);
        end while (!(lrck_q == CHAN_RIGHT && audio_lrck == CHAN_LEFT));
        sclk_q = audio_sclk;
        lrck_q = audio_lrck;
        mclk_out_start = mclk_out_n;
        while (rises < 2 * `CORE_I2S_SLOT + 1) begin
            @(negedge audgen_mclk);
            mclk_n++;
            mclk_total++;
            if (audio_lrck != lrck_q) begin
                if (audio_lrck == CHAN_RIGHT) right_at = rises;
                else left_at = rises;
            end
            if (!sclk_q && audio_sclk) begin
                rises++;
                if (rises >= 2) begin
                    check_word("audio_sclk period", mclk_n, `CORE_SCLK_DIV);
                    // first bit after lrck moves belongs to the old slot
                    bits = {bits[62:0], audio_dac};
                end
                mclk_n = 0;
            end
            sclk_q = audio_sclk;
            lrck_q = audio_lrck;
        end
        check_sample("audio_dac left sample", bits[63:48], exp_left);
        check_sample("audio_dac left padding", bits[47:32], '0);
        check_sample("audio_dac right sample", bits[31:16], exp_right);
        check_sample("audio_dac right padding", bits[15:0], '0);
        check_word("audio_lrck right slot start", right_at, `CORE_I2S_SLOT);
        check_word("audio_lrck period", left_at, 2 * `CORE_I2S_SLOT);
        // forwarded codec clock runs one for one with audgen_mclk
        check_word("audio_mclk cycles", mclk_out_n - mclk_out_start, mclk_total);
    endtask

    task automatic report_counts;
        $display("error counts: word %0d, rgb %0d, sample %0d, assertion %0d",
                 word_errs, rgb_errs, sample_errs, dut_i.timing_chk_i.err_cnt);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        word_t got;
        reset_n        <= 1'b0;
        bridge_addr    <= '0;
        bridge_rd      <= 1'b0;
        bridge_wr      <= 1'b0;
        bridge_wr_data <= '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge audgen_mclk);
        reset_n <= 1'b1;

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (tbl_wr[i]) write_reg(tbl_addr[i], tbl_wdata[i]);
            read_reg(tbl_addr[i], got);
            check_word($sformatf("bridge_rd_data row %0d", i), got, tbl_exp[i]);
        end

        fork
            check_frame();
            check_audio();
        join

        // count advanced the cycle after the last vs
        read_reg(addr_of(`CORE_REG_REGION, REG_FRAME_COUNT), got);
        check_word("frame count", got, word_t'(vs_count));

        report_counts();
        if (word_errs + rgb_errs + sample_errs + dut_i.timing_chk_i.err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: checks did not finish within %0d cycles", WATCHDOG_CYCLES);
        report_counts();
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/core_top_checker.sv
/*
  concurrent timing checks, bound into core_top
  rgb is compared with the fill value one cycle earlier, since video_rgb is registered
*/
`default_nettype none

module core_top_checker (
    input logic              audgen_mclk,
    input logic              reset_n,
    input logic              video_vs,
    input logic              video_hs,
    input logic              video_de,
    input core_av_pkg::rgb_t video_rgb,
    input core_av_pkg::rgb_t fill_rgb,
    input logic              audio_sclk,
    input logic              audio_lrck
);
    timeunit 1ns;
    timeprecision 1ps;

    // failures so far, read by the testbench
    int err_cnt = 0;

    //////////////////////////////
    // video
    //////////////////////////////

    vs_one_cycle: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n) video_vs |=> !video_vs
    ) else begin
        err_cnt = err_cnt + 1;
        $error("video_vs high for more than one cycle");
    end

    hs_one_cycle: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n) video_hs |=> !video_hs
    ) else begin
        err_cnt = err_cnt + 1;
        $error("video_hs high for more than one cycle");
    end

    // fill colour registered one cycle behind the register block
    de_shows_fill: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n) video_de |-> video_rgb == $past(fill_rgb)
    ) else begin
        err_cnt = err_cnt + 1;
        $error("video_rgb differs from the fill colour while video_de is high");
    end

    //////////////////////////////
    // audio
    //////////////////////////////

    lrck_on_sclk_fall: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n) $changed(audio_lrck) |-> $fell(audio_sclk)
    ) else begin
        err_cnt = err_cnt + 1;
        $error("audio_lrck moved away from a falling audio_sclk edge");
    end

endmodule

bind core_top core_top_checker timing_chk_i (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .video_vs    (video_vs),
    .video_hs    (video_hs),
    .video_de    (video_de),
    .video_rgb   (video_rgb),
    .fill_rgb    (cfg_i.fill_rgb),
    .audio_sclk  (audio_sclk),
    .audio_lrck  (audio_lrck)
);

`default_nettype wire

// File: rtl/core_top.sv
/*
  core top, bridge registers, video timing and I2S on one clock
  audgen_mclk is 12.288 MHz and doubles as the pixel clock
  audio_mclk is that same clock forwarded to the codec
*/
`default_nettype none

module core_top (
    input  logic                audgen_mclk,
    input  logic                reset_n,

    // bridge bus
    input  core_bus_pkg::word_t bridge_addr,
    input  logic                bridge_rd,
    input  logic                bridge_wr,
    input  core_bus_pkg::word_t bridge_wr_data,
    output core_bus_pkg::word_t bridge_rd_data,

    // video to scaler
    output core_av_pkg::rgb_t   video_rgb,
    output logic                video_de,
    output logic                video_hs,
    output logic                video_vs,
    output logic                video_skip,

    // i2s to codec
    output logic                audio_mclk,
    output logic                audio_sclk,
    output logic                audio_lrck,
    output logic                audio_dac
);

    // settings and frame count between the blocks
    core_cfg_if cfg_i ();

    ////////////////////////////////
    // bridge decode
    ////////////////////////////////

    core_regs regs_i (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cfg            (cfg_i.regs)
    );

    ////////////////////////////////
    // video and audio generation
    ////////////////////////////////

    video_timing video_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .cfg         (cfg_i.video),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .video_skip  (video_skip)
    );

    i2s_tx i2s_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .cfg         (cfg_i.audio),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    // codec master clock
    assign audio_mclk = audgen_mclk;

endmodule

`default_nettype wire

// File: rtl/i2s_tx.sv
/*
  I2S transmitter, sclk = mclk/4, 32 bit clocks per channel
  16 data bits MSB first, then zeros; data starts one bit after lrck moves
  both samples are latched at the start of the left slot
*/
`default_nettype none
`include "core_macros.svh"

module i2s_tx (
    input  logic      audgen_mclk,
    input  logic      reset_n,
    core_cfg_if.audio cfg,
    output logic      audio_sclk,
    output logic      audio_lrck,
    output logic      audio_dac
);
    import core_av_pkg::*;

    localparam int DIV_W  = $clog2(`CORE_SCLK_DIV);
    localparam int SLOT_W = $clog2(`CORE_I2S_SLOT);

    logic [DIV_W-1:0]  div_q;
    logic [SLOT_W-1:0] slot_q;
    logic              fall_en;
    logic              slot_end;
    i2s_chan_e         lrck_q;
    sample_t           shift_q;
    sample_t           right_q;

    ////////////////////////////////
    // bit clock
    ////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // top divider bit is sclk, low after reset
    assign audio_sclk = div_q[DIV_W-1];
    // last phase before sclk drops
    assign fall_en    = (div_q == DIV_W'(`CORE_SCLK_DIV - 1));
    assign slot_end   = (slot_q == SLOT_W'(`CORE_I2S_SLOT - 1));

    ////////////////////////////////
    // slot, lrck and shifter
    ////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_q    <= '0;
            lrck_q    <= CHAN_LEFT;
            shift_q   <= '0;
            right_q   <= '0;
            audio_dac <= 1'b0;
        end else if (fall_en) begin
            // the bit going out here is still the previous slot's last one
            audio_dac <= shift_q[`CORE_I2S_BITS-1];
            slot_q    <= slot_end ? '0 : slot_q + 1'b1;
            if (!slot_end) begin
                shift_q <= {shift_q[`CORE_I2S_BITS-2:0], 1'b0};
            end else if (lrck_q == CHAN_RIGHT) begin
                // new stereo pair, left goes straight into the shifter
                lrck_q  <= CHAN_LEFT;
                shift_q <= cfg.audio_left;
                right_q <= cfg.audio_right;
            end else begin
                lrck_q  <= CHAN_RIGHT;
                shift_q <= right_q;
            end
        end
    end

    assign audio_lrck = lrck_q;

endmodule

`default_nettype wire

// File: rtl/video_timing.sv
/*
  320x240 timing in a 400x512 raster, one pixel per audgen_mclk cycle
  every output is registered one cycle behind the counter state
  the active area shows the fill colour only
*/
`default_nettype none
`include "core_macros.svh"

module video_timing (
    input  logic              audgen_mclk,
    input  logic              reset_n,
    core_cfg_if.video         cfg,
    output core_av_pkg::rgb_t video_rgb,
    output logic              video_de,
    output logic              video_hs,
    output logic              video_vs,
    output logic              video_skip
);
    import core_av_pkg::*;

    coord_t x_q;
    coord_t y_q;
    logic   x_end;
    logic   y_end;
    logic   h_active;
    logic   v_active;
    logic   frame_top;

    ////////////////////////////////
    // raster counters
    ////////////////////////////////

    assign x_end = (x_q == coord_t'(`CORE_H_TOTAL - 1));
    assign y_end = (y_q == coord_t'(`CORE_V_TOTAL - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_q <= '0;
            y_q <= '0;
        end else if (x_end) begin
            x_q <= '0;
            // y only moves at end of line
            y_q <= y_end ? '0 : y_q + 1'b1;
        end else begin
            x_q <= x_q + 1'b1;
        end
    end

    // window of the active area, back porch first
    assign h_active = (x_q >= coord_t'(`CORE_H_BPORCH)) &&
                      (x_q <  coord_t'(`CORE_H_BPORCH + `CORE_H_ACTIVE));
    assign v_active = (y_q >= coord_t'(`CORE_V_BPORCH)) &&
                      (y_q <  coord_t'(`CORE_V_BPORCH + `CORE_V_ACTIVE));
    assign frame_top = (x_q == '0) && (y_q == '0);

    ////////////////////////////////
    // registered outputs
    ////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_vs        <= 1'b0;
            video_hs        <= 1'b0;
            video_de        <= 1'b0;
            video_rgb       <= '0;
            cfg.frame_start <= 1'b0;
        end else begin
            video_vs        <= frame_top;
            cfg.frame_start <= frame_top;
            video_hs        <= (x_q == coord_t'(`CORE_HS_X));
            video_de        <= h_active && v_active;
            // black outside the active area
            video_rgb       <= (h_active && v_active) ? cfg.fill_rgb : '0;
        end
    end

    // counts the cycle after each vs pulse
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            cfg.frame_count <= '0;
        end else if (cfg.frame_start) begin
            cfg.frame_count <= cfg.frame_count + 1'b1;
        end
    end

    // no frames are dropped
    assign video_skip = 1'b0;

endmodule

`default_nettype wire

// File: rtl/core_regs.sv
/*
  bridge register file, one 16-byte block in region CORE_REG_REGION
  writes take effect on the bridge_wr edge, no acknowledge, no stall
  read data is combinational from the address, bridge_rd changes nothing
*/
`default_nettype none
`include "core_macros.svh"

module core_regs (
    input  logic                audgen_mclk,
    input  logic                reset_n,
    input  core_bus_pkg::word_t bridge_addr,
    input  logic                bridge_rd,
    input  logic                bridge_wr,
    input  core_bus_pkg::word_t bridge_wr_data,
    output core_bus_pkg::word_t bridge_rd_data,
    core_cfg_if.regs            cfg
);
    import core_bus_pkg::*;

    logic     in_region;
    reg_sel_e sel;

    ////////////////////////////////
    // address decode
    ////////////////////////////////

    // only the top byte picks the region, as on the platform bus
    assign in_region = (bridge_addr[31:24] == `CORE_REG_REGION);
    assign sel       = reg_sel_e'(bridge_addr[3:2]);

    ////////////////////////////////
    // write side
    ////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            cfg.fill_rgb    <= '0;
            cfg.audio_left  <= '0;
            cfg.audio_right <= '0;
        end else if (bridge_wr && in_region) begin
            case (sel)
                REG_FILL_RGB:    cfg.fill_rgb    <= bridge_wr_data[23:0];
                REG_AUDIO_LEFT:  cfg.audio_left  <= bridge_wr_data[15:0];
                REG_AUDIO_RIGHT: cfg.audio_right <= bridge_wr_data[15:0];
                // frame count belongs to video timing
                default: ;
            endcase
        end
    end

    ////////////////////////////////
    // read mux
    ////////////////////////////////

    // bridge_rd is part of the platform bus but the mux does not need it
    always_comb begin
        bridge_rd_data = '0;
        if (in_region) begin
            case (sel)
                REG_FILL_RGB:    bridge_rd_data = {8'h00, cfg.fill_rgb};
                // samples read back zero extended
                REG_AUDIO_LEFT:  bridge_rd_data = {16'h0000, cfg.audio_left};
                REG_AUDIO_RIGHT: bridge_rd_data = {16'h0000, cfg.audio_right};
                REG_FRAME_COUNT: bridge_rd_data = {16'h0000, cfg.frame_count};
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/core_cfg_if.sv
/*
  settings from the register block to the generators, plus the frame count back
  all signals are synchronous to audgen_mclk
*/
`default_nettype none

interface core_cfg_if;
    import core_av_pkg::*;

    // driven by the register block
    rgb_t    fill_rgb;
    sample_t audio_left;
    sample_t audio_right;

    // driven by video timing
    frame_t  frame_count;
    logic    frame_start;

    modport regs  (output fill_rgb, output audio_left, output audio_right, input frame_count);
    modport video (input fill_rgb, output frame_count, output frame_start);
    // audio sees the samples only
    modport audio (input audio_left, input audio_right);

endinterface

`default_nettype wire

// File: rtl/core_av_pkg.sv
/*
  audio and video types shared by the generators
  i2s_chan_e values are the lrck level on the wire
*/
`default_nettype none

package core_av_pkg;

    // 8:8:8 pixel, red in the top byte
    typedef logic [23:0] rgb_t;

    // signed pcm sample
    typedef logic signed [15:0] sample_t;

    // x and y counters, wide enough for 512
    typedef logic [9:0] coord_t;

    // frames since reset, wraps
    typedef logic [15:0] frame_t;

    // lrck low for left, high for right
    typedef enum logic {
        CHAN_LEFT  = 1'b0,
        CHAN_RIGHT = 1'b1
    } i2s_chan_e;

endpackage

`default_nettype wire

// File: rtl/core_bus_pkg.sv
/*
  bridge side types
  register select comes from address bits 3:2 only
*/
`default_nettype none

package core_bus_pkg;

    // one bridge data or address word
    typedef logic [31:0] word_t;

    // register select, taken from addr[3:2]
    // samples use the low 16 bits only
    // frame count is read only
    typedef enum logic [1:0] {
        REG_FILL_RGB    = 2'd0,
        REG_AUDIO_LEFT  = 2'd1,
        REG_AUDIO_RIGHT = 2'd2,
        REG_FRAME_COUNT = 2'd3
    } reg_sel_e;

endpackage

`default_nettype wire

// File: rtl/core_macros.svh
/*
  video geometry, I2S framing and bridge decode constants
  geometry assumes a 12.288 MHz pixel clock, 400x512 total, 320x240 active
  CORE_SCLK_DIV must stay 4, since the divider uses its top bit as sclk
*/
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// video line and frame geometry, in pixel clocks and lines
`define CORE_H_TOTAL    400
`define CORE_V_TOTAL    512
`define CORE_H_ACTIVE   320
`define CORE_V_ACTIVE   240
`define CORE_H_BPORCH   10
`define CORE_V_BPORCH   10
// hs lands a few pixels after vs
`define CORE_HS_X       3

// i2s framing
`define CORE_SCLK_DIV   4
`define CORE_I2S_SLOT   32
`define CORE_I2S_BITS   16

// top address byte of the register block
`define CORE_REG_REGION 8'h10

`endif
